/* hdl/dma_req_pkg.sv */
// DMA initiator request side shared definitions
// Request table entry, NoC header and flit types
`default_nettype none

package dma_req_pkg;

  //////////////////////////////
  // Sizing
  //////////////////////////////

  // Request table depth and entry index width
  localparam int table_entries = 4;
  localparam int entry_idx_w   = 2;

  // Transfer size field, counted in 32-bit words
  localparam int size_w = 12;

  // Flits per NoC packet, header and address flit included
  localparam int noc_packet_size = 8;
  localparam int max_pkt_words   = noc_packet_size - 2;
  // Enough bits to count up to a full packet of data words
  localparam int pkt_cnt_w       = $clog2(max_pkt_words + 1);

  //////////////////////////////
  // NoC encodings
  //////////////////////////////

  localparam logic [4:0] tile_id          = 5'd3;
  localparam logic [2:0] packet_class_dma = 3'd2;
  localparam logic [3:0] pkt_type_l2r_req = 4'd1;
  localparam logic [3:0] pkt_type_r2l_req = 4'd2;

  // Top bit set marks the final flit of a packet
  typedef enum logic [1:0] {
    ftype_payload = 2'b00,
    ftype_header  = 2'b01,
    ftype_last    = 2'b10
  } flit_type_t;

  //////////////////////////////
  // Types
  //////////////////////////////

  // One request table entry
  typedef struct packed {
    logic              is_l2r;
    logic [4:0]        rtile;
    logic [size_w-1:0] size;
    logic [31:0]       raddr;
    logic [31:0]       laddr;
  } dma_req_t;

  // Header word, MSB first
  typedef struct packed {
    logic [4:0]        dest;
    logic [2:0]        pkt_class;
    logic [4:0]        source;
    logic [3:0]        pkt_type;
    logic [1:0]        pkt_id;
    logic              req_last;
    logic [size_w-1:0] size;
  } noc_hdr_t;

  // Header on header flits, plain data everywhere else
  typedef union packed {
    noc_hdr_t    hdr;
    logic [31:0] raw;
  } flit_content_u;

  typedef struct packed {
    flit_type_t    ftype;
    flit_content_u content;
  } noc_flit_t;

  // DMA class header sent from this tile
  function automatic noc_hdr_t dma_hdr(input logic [4:0] dest, input logic [3:0] pkt_type,
                                       input logic [1:0] pkt_id, input logic req_last,
                                       input logic [size_w-1:0] size);
    noc_hdr_t h;
    h.dest      = dest;
    h.pkt_class = packet_class_dma;
    h.source    = tile_id;
    h.pkt_type  = pkt_type;
    h.pkt_id    = pkt_id;
    h.req_last  = req_last;
    h.size      = size;
    return h;
  endfunction

endpackage

`default_nettype wire

/* hdl/dma_initiator_ctrl.sv */
// DMA request controller
// Round-robin entry selection, start pulse, open-response tracking and flit merge
`default_nettype none

module dma_initiator_ctrl import dma_req_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  // Request table
  input  logic [table_entries-1:0] valid,
  input  dma_req_t                 ctrl_read_req,
  output logic [entry_idx_w-1:0]   ctrl_read_pos,
  // Response path feedback
  input  logic                     ctrl_done_en,
  input  logic [entry_idx_w-1:0]   ctrl_done_pos,
  // Packetizer control
  output logic                     l2r_start,
  output logic                     r2l_start,
  output logic                     req_start,
  input  noc_flit_t                l2r_flit,
  input  logic                     l2r_valid,
  input  logic                     l2r_last,
  input  logic                     l2r_done,
  input  noc_flit_t                r2l_flit,
  input  logic                     r2l_valid,
  input  logic                     r2l_last,
  input  logic                     r2l_done,
  // Merged NoC output
  output noc_flit_t                noc_out_flit,
  output logic                     noc_out_valid,
  output logic                     noc_out_last
);

  // One-hot grant, held until the next start
  logic [table_entries-1:0] grant;
  logic [table_entries-1:0] nxt_grant;
  // Entries sent but still waiting for their response
  logic [table_entries-1:0] open_set;
  logic [table_entries-1:0] nxt_open_set;
  logic [table_entries-1:0] eligible;
  logic                     busy;
  logic                     dir_l2r;
  logic                     pkt_done;
  // Round-robin search state
  logic [entry_idx_w-1:0]   rr_base;
  logic                     rr_found;
  int unsigned              rr_idx;

  //////////////////////////////
  // Arbitration
  //////////////////////////////

  assign eligible = valid & ~open_set;

  // Search starts after the last grant, at entry 0 out of reset
  assign rr_base = (grant == '0) ? entry_idx_w'(table_entries - 1) : ctrl_read_pos;

  always_comb begin
    nxt_grant = '0;
    rr_found  = 1'b0;
    rr_idx    = 0;
    for (int off = 1; off <= table_entries; off++) begin
      rr_idx = (int'(rr_base) + off) % table_entries;
      if (!rr_found && eligible[rr_idx]) begin
        nxt_grant[rr_idx] = 1'b1;
        rr_found          = 1'b1;
      end
    end
  end

  // One-hot to index
  always_comb begin
    ctrl_read_pos = '0;
    for (int i = 0; i < table_entries; i++) begin
      if (grant[i]) ctrl_read_pos = ctrl_read_pos | entry_idx_w'(i);
    end
  end

  //////////////////////////////
  // Start, busy and open set
  //////////////////////////////

  // Only the packetizer that owns the transfer reports done
  assign pkt_done = dir_l2r ? l2r_done : r2l_done;

  // Finished entry joins, response completion leaves
  always_comb begin
    nxt_open_set = open_set;
    if (pkt_done) nxt_open_set = nxt_open_set | grant;
    if (ctrl_done_en) nxt_open_set[ctrl_done_pos] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant     <= '0;
      busy      <= 1'b0;
      req_start <= 1'b0;
      dir_l2r   <= 1'b0;
      open_set  <= '0;
    end else begin
      req_start <= 1'b0;
      if (!busy && (|eligible)) begin
        grant     <= nxt_grant;
        busy      <= 1'b1;
        req_start <= 1'b1;
      end else if (pkt_done) begin
        busy <= 1'b0;
      end
      // Entry fields are valid while the start pulse is high
      if (req_start) dir_l2r <= ctrl_read_req.is_l2r;
      open_set <= nxt_open_set;
    end
  end

  // Start goes to one packetizer only
  assign l2r_start = req_start && ctrl_read_req.is_l2r;
  assign r2l_start = req_start && !ctrl_read_req.is_l2r;

  // Output merge by stored direction
  assign noc_out_flit  = dir_l2r ? l2r_flit : r2l_flit;
  assign noc_out_valid = dir_l2r ? l2r_valid : r2l_valid;
  assign noc_out_last  = dir_l2r ? l2r_last : r2l_last;

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("ERROR: grant not one-hot");

  // Both packetizers back in idle whenever a new transfer starts
  a_start_from_idle: assert property (@(posedge clk) disable iff (rst)
    req_start |-> !l2r_valid && !r2l_valid)
    else $error("ERROR: start pulse while a packetizer is active");

  a_done_while_busy: assert property (@(posedge clk) disable iff (rst)
    (l2r_done || r2l_done) |-> busy && !req_start)
    else $error("ERROR: done pulse outside a transfer");

endmodule

`default_nettype wire

/* hdl/dma_l2r_packetizer.sv */
// L2R write packetizer
// Splits a transfer into header, address and data flit packets
`default_nettype none

module dma_l2r_packetizer import dma_req_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  dma_req_t               req,
  input  logic [entry_idx_w-1:0] pkt_id,
  // NoC side
  input  logic                   noc_ready,
  output noc_flit_t              flit,
  output logic                   flit_valid,
  output logic                   flit_last,
  output logic                   done,
  // Data source
  input  logic                   data_valid,
  input  logic [31:0]            data,
  output logic                   data_ready
);

  typedef enum logic [1:0] {
    st_idle,
    st_hdr,
    st_addr,
    st_data
  } state_t;

  state_t                 state;
  // Words already sent for this request
  logic [size_w-1:0]      words_sent;
  // Words sent within the current packet
  logic [pkt_cnt_w-1:0]   pkt_cnt;
  logic [pkt_cnt_w-1:0]   pkt_len;
  logic                   last_pkt_q;
  // Header-time sizing of the next packet
  logic [size_w-1:0]      remaining;
  logic                   last_pkt;
  logic [pkt_cnt_w-1:0]   pkt_words;
  logic                   pkt_end;
  logic                   data_xfer;

  //////////////////////////////
  // Packet sizing
  //////////////////////////////

  assign remaining = req.size - words_sent;
  // Fits in one packet, so this header closes the request
  assign last_pkt  = remaining <= size_w'(max_pkt_words);
  assign pkt_words = last_pkt ? pkt_cnt_w'(remaining) : pkt_cnt_w'(max_pkt_words);

  assign pkt_end   = pkt_cnt_w'(pkt_cnt + 1'b1) == pkt_len;
  assign data_xfer = (state == st_data) && data_valid && noc_ready;

  //////////////////////////////
  // Flit generation
  //////////////////////////////

  always_comb begin
    flit       = '0;
    flit_valid = 1'b0;
    case (state)
      st_hdr: begin
        flit_valid       = 1'b1;
        flit.ftype       = ftype_header;
        flit.content.hdr = dma_hdr(req.rtile, pkt_type_l2r_req, pkt_id, last_pkt,
                                   size_w'(pkt_words));
      end
      st_addr: begin
        // Remote address advances by one word per word already sent
        flit_valid       = 1'b1;
        flit.ftype       = ftype_payload;
        flit.content.raw = req.raddr + 32'({words_sent, 2'b00});
      end
      st_data: begin
        // Data flits follow the source
        flit_valid       = data_valid;
        flit.ftype       = pkt_end ? ftype_last : ftype_payload;
        flit.content.raw = data;
      end
      default: begin
        flit_valid = 1'b0;
      end
    endcase
  end

  // Last flag only while the final data flit is on offer
  assign flit_last  = (state == st_data) && pkt_end && data_valid;
  // Word is consumed only when it goes out on the NoC
  assign data_ready = data_xfer;
  assign done       = data_xfer && pkt_end && last_pkt_q;

  //////////////////////////////
  // State and counters
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      words_sent <= '0;
      pkt_cnt    <= '0;
      pkt_len    <= '0;
      last_pkt_q <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state      <= st_hdr;
            words_sent <= '0;
          end
        end
        st_hdr: begin
          if (noc_ready) begin
            state      <= st_addr;
            pkt_len    <= pkt_words;
            last_pkt_q <= last_pkt;
            pkt_cnt    <= '0;
          end
        end
        st_addr: begin
          if (noc_ready) state <= st_data;
        end
        st_data: begin
          if (data_xfer) begin
            words_sent <= words_sent + 1'b1;
            pkt_cnt    <= pkt_cnt + 1'b1;
            // Next header, or back to idle after the final packet
            if (pkt_end) state <= last_pkt_q ? st_idle : st_hdr;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // A word is taken only on a NoC transfer and never past the packet or the request
  a_data_with_ready: assert property (@(posedge clk) disable iff (rst)
    data_ready |-> noc_ready && (pkt_cnt < pkt_len) && (words_sent < req.size))
    else $error("ERROR: data word taken outside a packet or past the request size");

endmodule

`default_nettype wire

/* hdl/dma_r2l_packetizer.sv */
// R2L read-request packetizer
// Header, size, remote address and local address flits
`default_nettype none

module dma_r2l_packetizer import dma_req_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  dma_req_t               req,
  input  logic [entry_idx_w-1:0] pkt_id,
  input  logic                   noc_ready,
  output noc_flit_t              flit,
  output logic                   flit_valid,
  output logic                   flit_last,
  output logic                   done
);

  typedef enum logic [2:0] {
    st_idle,
    st_hdr,
    st_size,
    st_raddr,
    st_laddr
  } state_t;

  state_t state;

  //////////////////////////////
  // Flit generation
  //////////////////////////////

  always_comb begin
    flit = '0;
    case (state)
      st_hdr: begin
        // Single packet request, size travels in the next flit
        flit.ftype       = ftype_header;
        flit.content.hdr = dma_hdr(req.rtile, pkt_type_r2l_req, pkt_id, 1'b1, '0);
      end
      st_size: begin
        flit.ftype       = ftype_payload;
        flit.content.raw = 32'(req.size);
      end
      st_raddr: begin
        flit.ftype       = ftype_payload;
        flit.content.raw = req.raddr;
      end
      st_laddr: begin
        flit.ftype       = ftype_last;
        flit.content.raw = req.laddr;
      end
      default: begin
        flit.ftype = ftype_payload;
      end
    endcase
  end

  assign flit_valid = state != st_idle;
  assign flit_last  = state == st_laddr;
  assign done       = (state == st_laddr) && noc_ready;

  // Each flit advances on its own transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:  if (start) state <= st_hdr;
        st_hdr:   if (noc_ready) state <= st_size;
        st_size:  if (noc_ready) state <= st_raddr;
        st_raddr: if (noc_ready) state <= st_laddr;
        st_laddr: if (noc_ready) state <= st_idle;
        default:  state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/dma_initiator_request.sv */
// DMA initiator request path top
// Controller with the L2R and R2L packetizers on one NoC port
`default_nettype none

module dma_initiator_request import dma_req_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  // NoC output
  output noc_flit_t                noc_out_flit,
  output logic                     noc_out_last,
  output logic                     noc_out_valid,
  input  logic                     noc_out_ready,
  // Request table
  output logic [entry_idx_w-1:0]   ctrl_read_pos,
  input  dma_req_t                 ctrl_read_req,
  input  logic [table_entries-1:0] valid,
  // Response path feedback
  input  logic [entry_idx_w-1:0]   ctrl_done_pos,
  input  logic                     ctrl_done_en,
  // Local side request and data source
  output logic                     req_start,
  output logic [31:0]              req_laddr,
  input  logic                     req_data_valid,
  output logic                     req_data_ready,
  input  logic [31:0]              req_data,
  output logic                     req_is_l2r,
  output logic [size_w-1:0]        req_size
);

  logic      l2r_start;
  logic      r2l_start;
  noc_flit_t l2r_flit;
  logic      l2r_valid;
  logic      l2r_last;
  logic      l2r_done;
  noc_flit_t r2l_flit;
  logic      r2l_valid;
  logic      r2l_last;
  logic      r2l_done;

  // Entry fields for the local side
  assign req_laddr  = ctrl_read_req.laddr;
  assign req_is_l2r = ctrl_read_req.is_l2r;
  assign req_size   = ctrl_read_req.size;

  dma_initiator_ctrl dma_initiator_ctrl_inst (
    .clk, .rst, .valid, .ctrl_read_req, .ctrl_read_pos, .ctrl_done_en, .ctrl_done_pos,
    .l2r_start, .r2l_start, .req_start,
    .l2r_flit, .l2r_valid, .l2r_last, .l2r_done,
    .r2l_flit, .r2l_valid, .r2l_last, .r2l_done,
    .noc_out_flit, .noc_out_valid, .noc_out_last
  );

  dma_l2r_packetizer dma_l2r_packetizer_inst (
    .clk, .rst, .start(l2r_start), .req(ctrl_read_req), .pkt_id(ctrl_read_pos),
    .noc_ready(noc_out_ready), .flit(l2r_flit), .flit_valid(l2r_valid),
    .flit_last(l2r_last), .done(l2r_done),
    .data_valid(req_data_valid), .data(req_data), .data_ready(req_data_ready)
  );

  dma_r2l_packetizer dma_r2l_packetizer_inst (
    .clk, .rst, .start(r2l_start), .req(ctrl_read_req), .pkt_id(ctrl_read_pos),
    .noc_ready(noc_out_ready), .flit(r2l_flit), .flit_valid(r2l_valid),
    .flit_last(r2l_last), .done(r2l_done)
  );

endmodule

`default_nettype wire

/* dv/tb_dma_initiator_request.sv */
// Testbench for the DMA initiator request path
// Request table, data source, expected flit stream and checking assertions
`default_nettype none

module tb_dma_initiator_request import dma_req_pkg::*; ();

  localparam int worst_flits = 64;
  localparam int data_words  = 64;

  logic                     clk;
  logic                     rst;
  noc_flit_t                noc_out_flit;
  logic                     noc_out_last;
  logic                     noc_out_valid;
  logic                     noc_out_ready;
  logic [entry_idx_w-1:0]   ctrl_read_pos;
  dma_req_t                 ctrl_read_req;
  logic [table_entries-1:0] valid;
  logic [entry_idx_w-1:0]   ctrl_done_pos;
  logic                     ctrl_done_en;
  logic                     req_start;
  logic [31:0]              req_laddr;
  logic                     req_data_valid;
  logic                     req_data_ready;
  logic [31:0]              req_data;
  logic                     req_is_l2r;
  logic [size_w-1:0]        req_size;

  // Request table and data source contents
  dma_req_t    tbl [table_entries];
  logic [31:0] data_mem [data_words];
  // Expected flits, bit 34 is the NoC last flag
  logic [34:0] exp_q [$];
  logic [34:0] exp_head;
  int          exp_cnt;
  int          alloc_idx;
  int          data_idx;
  logic        word_taken;
  // Entries granted and still waiting for their response
  logic [table_entries-1:0] pending;
  logic [entry_idx_w-1:0]   last_pos;
  logic [entry_idx_w-1:0]   rr_expect;
  logic [entry_idx_w-1:0]   done_idx;
  // Table entry the round robin should pick next
  dma_req_t    exp_req;
  int          cycle;
  int          done_due;
  logic        idle_phase;
  logic [31:0] rng;

  assign ctrl_read_req = tbl[ctrl_read_pos];
  assign exp_req       = tbl[rr_expect];

  dma_initiator_request dma_initiator_request_inst (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  // Next grant by round robin over valid entries without an open response
  always_comb begin
    logic found;
    int   idx;
    found     = 1'b0;
    rr_expect = '0;
    for (int off = 1; off <= table_entries; off++) begin
      idx = (int'(last_pos) + off) % table_entries;
      if (!found && valid[idx] && !pending[idx]) begin
        rr_expect = entry_idx_w'(idx);
        found     = 1'b1;
      end
    end
  end

  ////////////////////////////////
  // Expected flit stream
  ////////////////////////////////

  task automatic queue_request(input logic [entry_idx_w-1:0] idx);
    dma_req_t          r;
    noc_hdr_t          h;
    int                sent;
    int                n;
    logic              last;
    r    = tbl[idx];
    sent = 0;
    h.dest      = r.rtile;
    h.pkt_class = packet_class_dma;
    h.source    = tile_id;
    h.pkt_id    = idx;
    if (r.is_l2r) begin
      h.pkt_type = pkt_type_l2r_req;
      while (sent < int'(r.size)) begin
        n          = (int'(r.size) - sent > 6) ? 6 : int'(r.size) - sent;
        last       = (sent + n) == int'(r.size);
        h.req_last = last;
        h.size     = size_w'(n);
        exp_q.push_back({1'b0, ftype_header, h});
        exp_q.push_back({1'b0, ftype_payload, r.raddr + 32'(sent * 4)});
        for (int k = 0; k < n; k++) begin
          if (k == n - 1) exp_q.push_back({1'b1, ftype_last, data_mem[alloc_idx]});
          else exp_q.push_back({1'b0, ftype_payload, data_mem[alloc_idx]});
          alloc_idx++;
        end
        sent += n;
      end
    end else begin
      h.pkt_type = pkt_type_r2l_req;
      h.req_last = 1'b1;
      h.size     = '0;
      exp_q.push_back({1'b0, ftype_header, h});
      exp_q.push_back({1'b0, ftype_payload, 32'(r.size)});
      exp_q.push_back({1'b0, ftype_payload, r.raddr});
      exp_q.push_back({1'b1, ftype_last, r.laddr});
    end
  endtask

  // Model update on each rising edge, before the DUT registers change
  always @(posedge clk) begin
    if (rst) begin
      cycle      = 0;
      done_due   = -1;
      done_idx   = '0;
      pending    = '0;
      last_pos   = entry_idx_w'(table_entries - 1);
      word_taken = 1'b0;
      data_idx   = 0;
      alloc_idx  = 0;
      exp_q.delete();
    end else begin
      cycle++;
      word_taken = req_data_ready;
      if (req_data_ready) data_idx++;
      if (noc_out_valid && noc_out_ready && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
        // Response comes back a few cycles after the request ends
        if (exp_q.size() == 0) begin
          done_due = cycle + 3;
          done_idx = last_pos;
        end
      end
      if (ctrl_done_en) pending[ctrl_done_pos] = 1'b0;
      if (req_start) begin
        last_pos               = ctrl_read_pos;
        pending[ctrl_read_pos] = 1'b1;
        queue_request(ctrl_read_pos);
      end
    end
    exp_cnt  = exp_q.size();
    exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
  end

  ////////////////////////////////
  // Checks
  ////////////////////////////////

  a_quiet: assert property (@(posedge clk) disable iff (rst)
    idle_phase |-> !noc_out_valid && !noc_out_last && !req_start && !req_data_ready)
    else report_fail($sformatf(
      "ERROR: noc_out_valid=%h noc_out_last=%h req_start=%h req_data_ready=%h when idle",
      $sampled(noc_out_valid), $sampled(noc_out_last), $sampled(req_start),
      $sampled(req_data_ready)));

  a_flit_expected: assert property (@(posedge clk) disable iff (rst)
    noc_out_valid |-> exp_cnt != 0)
    else report_fail("Flit offered on the NoC while no flit was expected");

  a_flit_value: assert property (@(posedge clk) disable iff (rst)
    noc_out_valid && noc_out_ready |-> noc_out_flit == exp_head[33:0])
    else report_fail($sformatf("ERROR: noc_out_flit got %h expected %h",
                               $sampled(noc_out_flit), $sampled(exp_head[33:0])));

  a_last_flag: assert property (@(posedge clk) disable iff (rst)
    noc_out_valid && noc_out_ready |-> noc_out_last == exp_head[34])
    else report_fail($sformatf("ERROR: noc_out_last got %h expected %h",
                               $sampled(noc_out_last), $sampled(exp_head[34])));

  // No last flag without a flit on offer
  a_last_valid: assert property (@(posedge clk) disable iff (rst)
    noc_out_last |-> noc_out_valid)
    else report_fail("NoC last flag raised while no flit was offered");

  // Offered flit holds while the NoC stalls
  a_stable: assert property (@(posedge clk) disable iff (rst)
    noc_out_valid && !noc_out_ready |=> noc_out_valid && $stable(noc_out_flit))
    else report_fail($sformatf("ERROR: noc_out_flit changed under back-pressure was %h now %h",
                               $past(noc_out_flit), $sampled(noc_out_flit)));

  a_rr_order: assert property (@(posedge clk) disable iff (rst)
    req_start |-> ctrl_read_pos == rr_expect)
    else report_fail($sformatf("ERROR: ctrl_read_pos got %h expected %h",
                               $sampled(ctrl_read_pos), $sampled(rr_expect)));

  a_no_regrant: assert property (@(posedge clk) disable iff (rst)
    req_start |-> !pending[ctrl_read_pos])
    else report_fail("Entry granted again before its response completed");

  // Granted entry fields on the local side with the start pulse
  a_req_laddr: assert property (@(posedge clk) disable iff (rst)
    req_start |-> req_laddr == exp_req.laddr)
    else report_fail($sformatf("ERROR: req_laddr got %h expected %h",
                               $sampled(req_laddr), $sampled(exp_req.laddr)));

  a_req_size: assert property (@(posedge clk) disable iff (rst)
    req_start |-> req_size == exp_req.size)
    else report_fail($sformatf("ERROR: req_size got %h expected %h",
                               $sampled(req_size), $sampled(exp_req.size)));

  a_req_is_l2r: assert property (@(posedge clk) disable iff (rst)
    req_start |-> req_is_l2r == exp_req.is_l2r)
    else report_fail($sformatf("ERROR: req_is_l2r got %h expected %h",
                               $sampled(req_is_l2r), $sampled(exp_req.is_l2r)));

  ////////////////////////////////
  // Stimulus
  ////////////////////////////////

  // One cycle of inputs, applied on the falling edge
  task automatic drive_cycle();
    @(negedge clk);
    rng           = lcg_next(rng);
    noc_out_ready = rng[17:16] != 2'b00;
    // A word stays offered until the DUT takes it
    if (word_taken || !req_data_valid) begin
      req_data       = data_mem[data_idx];
      req_data_valid = rng[9:8] != 2'b00;
    end
    ctrl_done_en = 1'b0;
    if (cycle == done_due) begin
      ctrl_done_en    = 1'b1;
      ctrl_done_pos   = done_idx;
      valid[done_idx] = 1'b0;
    end
  endtask

  task automatic run_until_clear();
    while (valid != '0 || exp_q.size() > 0 || ctrl_done_en) drive_cycle();
    repeat (2) drive_cycle();
  endtask

  task automatic load_entry(input int idx, input logic is_l2r, input logic [size_w-1:0] size,
                            input logic [31:0] raddr, input logic [31:0] laddr);
    tbl[idx].is_l2r = is_l2r;
    tbl[idx].rtile  = 5'(idx + 9);
    tbl[idx].size   = size;
    tbl[idx].raddr  = raddr;
    tbl[idx].laddr  = laddr;
    valid[idx]      = 1'b1;
    idle_phase      = 1'b0;
  endtask

  initial begin
    rng            = 32'h5ec8;
    rst            = 1'b1;
    valid          = '0;
    noc_out_ready  = 1'b0;
    ctrl_done_en   = 1'b0;
    ctrl_done_pos  = '0;
    req_data_valid = 1'b0;
    req_data       = '0;
    idle_phase     = 1'b1;
    for (int i = 0; i < table_entries; i++) tbl[i] = '0;
    for (int i = 0; i < data_words; i++) begin
      rng         = lcg_next(rng);
      data_mem[i] = rng;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // Quiet outputs with an empty table
    repeat (6) drive_cycle();

    // Single packet write, then a split write, then a read request
    load_entry(0, 1'b1, 12'd5, 32'h1000_0040, 32'h0000_0100);
    run_until_clear();
    load_entry(1, 1'b1, 12'd14, 32'h2000_0800, 32'h0000_0200);
    run_until_clear();
    load_entry(2, 1'b0, 12'd33, 32'h3000_1000, 32'h0000_0400);
    run_until_clear();

    // Full table, mixed directions
    load_entry(0, 1'b1, 12'd7, 32'h4000_0000, 32'h0000_0500);
    load_entry(1, 1'b0, 12'd9, 32'h5000_0010, 32'h0000_0600);
    load_entry(2, 1'b1, 12'd3, 32'h6000_0020, 32'h0000_0700);
    load_entry(3, 1'b0, 12'd20, 32'h7000_0030, 32'h0000_0800);
    run_until_clear();

    // Every source word taken exactly once
    if (data_idx != alloc_idx) begin
      report_fail($sformatf("ERROR: data words used %h expected %h", data_idx, alloc_idx));
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

  // Watchdog over twice the worst flit count at 20 cycles per flit
  initial begin
    #(2 * worst_flits * 20 * 10);
    $display("Timeout, the run did not finish in time");
    $display("Test failures found");
    $fatal(1);
  end

endmodule

`default_nettype wire

/* build.f */
hdl/dma_req_pkg.sv
hdl/dma_initiator_ctrl.sv
hdl/dma_l2r_packetizer.sv
hdl/dma_r2l_packetizer.sv
hdl/dma_initiator_request.sv
dv/tb_dma_initiator_request.sv

/* Makefile */
# Verilator build and run of the DMA initiator request testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_dma_initiator_request
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "All tests passed!" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
